// File: all.f
src/core_pkg.sv
src/axil_rd_if.sv
src/lat_counter.sv
src/dram_axil.sv
src/wb_ctrl.sv
src/wb.sv
src/regfile.sv
src/wb_subsys.sv
testbench/tb_wb_subsys.sv

// File: dram_init.hex
// One 32-bit data word per line, word address 0 to 15
8badf00d
12345678
80ff7f01
deadbeef
00c0ffee
7fff8000
a5a55a5a
fedcba98
01234567
ff00ff00
0000ffff
80000001
13579bdf
2468ace0
c3c3c3c3
55aa66bb

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_wb_subsys -f all.f -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log || true

if grep -qx "Regression passed" sim.log; then
    echo "Simulation finished without errors"
else
    echo "Simulation reported errors, see sim.log"
    exit 1
fi

// File: src/axil_rd_if.sv
`timescale 1ns/10ps

interface axil_rd_if #(
    parameter XLEN = 32
);

    logic [XLEN-1:0] araddr;
    logic            arvalid;
    logic            arready;

    logic [XLEN-1:0] rdata;
    logic      [1:0] rresp;
    logic            rvalid;
    logic            rready;

    modport master (
        output araddr, arvalid, rready,
        input  arready, rdata, rresp, rvalid
    );

    modport slave (
        input  araddr, arvalid, rready,
        output arready, rdata, rresp, rvalid
    );

endinterface

// File: src/core_pkg.sv
package core_pkg;

    // Source of the value written back to the destination register
    typedef enum logic [1:0] {
        RD_WR_ALU      = 2'b00,
        RD_WR_PC_INC_4 = 2'b01,
        RD_WR_PC_INC_2 = 2'b10,
        RD_WR_DRAM     = 2'b11
    } rd_wr_sel_e;

    // Load size and extension
    typedef enum logic [2:0] {
        DRAM_RD_B  = 3'b000,
        DRAM_RD_H  = 3'b001,
        DRAM_RD_W  = 3'b010,
        DRAM_RD_BU = 3'b100,
        DRAM_RD_HU = 3'b101
    } dram_rd_sel_e;

    localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

endpackage

// File: src/dram_axil.sv
`timescale 1ns/10ps

module dram_axil #(
    parameter XLEN       = 32,
    parameter DRAM_WORDS = 16,
    parameter DRAM_LAT   = 2
) (
    input logic clk_i,
    input logic reset_i,

    axil_rd_if.slave axil
);

localparam IDX_W = (DRAM_WORDS > 1) ? $clog2(DRAM_WORDS) : 1;
localparam LAT_W = (DRAM_LAT > 0) ? $clog2(DRAM_LAT + 1) : 1;

logic [XLEN-1:0] mem [DRAM_WORDS];

initial begin
    $readmemh("dram_init.hex", mem);
end

logic            busy_q;
logic            lat_done;
logic            in_range;
logic [XLEN-1:0] rdata_q;
logic      [1:0] rresp_q;

wire ar_hs = axil.arvalid && axil.arready;
wire r_hs  = axil.rvalid && axil.rready;

assign in_range = (axil.araddr[XLEN-1:2] < DRAM_WORDS);

lat_counter #(
    .WIDTH(LAT_W)
) lat_counter_inst (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .load_i (ar_hs),
    .count_i(LAT_W'(DRAM_LAT)),
    .done_o (lat_done)
);

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        busy_q <= 1'b0;
    end else if (ar_hs) begin
        busy_q <= 1'b1;
    end else if (r_hs) begin
        busy_q <= 1'b0;
    end
end

// Response is captured with the address and held until the R transfer
always_ff @(posedge clk_i) begin
    if (ar_hs) begin
        rdata_q <= in_range ? mem[axil.araddr[IDX_W+1:2]] : {XLEN{1'b0}};
        rresp_q <= in_range ? core_pkg::AXI_RESP_OKAY : core_pkg::AXI_RESP_SLVERR;
    end
end

assign axil.arready = !busy_q;             // One read in flight at a time
assign axil.rvalid  = busy_q && lat_done;
assign axil.rdata   = rdata_q;
assign axil.rresp   = rresp_q;

endmodule

// File: src/lat_counter.sv
`timescale 1ns/10ps

module lat_counter #(
    parameter WIDTH = 2
) (
    input  logic             clk_i,
    input  logic             reset_i,

    input  logic             load_i,
    input  logic [WIDTH-1:0] count_i,

    output logic             done_o
);

logic [WIDTH-1:0] count_q;

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        count_q <= '0;
    end else if (load_i) begin
        count_q <= count_i;
    end else if (count_q != '0) begin
        count_q <= count_q - 1'b1;
    end
end

assign done_o = (count_q == '0) && !load_i; // A fresh load hides the old zero

endmodule

// File: src/regfile.sv
`timescale 1ns/10ps

module regfile #(
    parameter XLEN = 32
) (
    input  logic            clk_i,
    input  logic            reset_i,

    input  logic            wr_en_i,
    input  logic      [4:0] wr_addr_i,
    input  logic [XLEN-1:0] wr_data_i,

    input  logic      [4:0] rs_addr_i,
    output logic [XLEN-1:0] rs_data_o
);

logic [XLEN-1:0] regs [32];

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        for (int i = 0; i < 32; i++) begin
            regs[i] <= {XLEN{1'b0}};
        end
    end else if (wr_en_i && (wr_addr_i != 5'd0)) begin
        regs[wr_addr_i] <= wr_data_i;
    end
end

assign rs_data_o = (rs_addr_i == 5'd0) ? {XLEN{1'b0}} : regs[rs_addr_i];

endmodule

// File: src/wb.sv
`timescale 1ns/10ps

module wb #(
    parameter XLEN = 32
) (
    input  logic                      rd_wr_en_i,
    input  core_pkg::rd_wr_sel_e      rd_wr_sel_i,
    input  logic                [4:0] rd_wr_addr_i,

    input  logic                      rd_wr_en_r_i,
    input  core_pkg::rd_wr_sel_e      rd_wr_sel_r_i,
    input  logic                [4:0] rd_wr_addr_r_i,
    input  core_pkg::dram_rd_sel_e    dram_rd_sel_r_i,

    input  logic           [XLEN-1:0] pc_data_i,
    input  logic           [XLEN-1:0] alu_data_i,

    input  logic           [XLEN-1:0] dram_rd_addr_i,
    input  logic           [XLEN-1:0] dram_rd_data_i,

    output logic                      reg_wr_en_o,
    output logic                [4:0] reg_wr_addr_o,
    output logic           [XLEN-1:0] reg_wr_data_o
);

logic      [1:0] byte_off;
logic [XLEN-1:0] ld_shifted;
logic [XLEN-1:0] ld_data;
logic [XLEN-1:0] direct_data;

wire [XLEN-1:0] pc_inc_4 = pc_data_i + 3'h4;
wire [XLEN-1:0] pc_inc_2 = pc_data_i + 3'h2;

wire load_pending = (rd_wr_sel_r_i == core_pkg::RD_WR_DRAM);

always_comb begin
    case (dram_rd_sel_r_i)
        core_pkg::DRAM_RD_B,
        core_pkg::DRAM_RD_BU: byte_off = dram_rd_addr_i[1:0];
        core_pkg::DRAM_RD_H,
        core_pkg::DRAM_RD_HU: byte_off = {dram_rd_addr_i[1], 1'b0};
        default:              byte_off = 2'b00; // Words are always aligned
    endcase
end

assign ld_shifted = dram_rd_data_i >> {byte_off, 3'b000};

always_comb begin
    case (dram_rd_sel_r_i)
        core_pkg::DRAM_RD_B:  ld_data = {{(XLEN-8){ld_shifted[7]}}, ld_shifted[7:0]};
        core_pkg::DRAM_RD_H:  ld_data = {{(XLEN-16){ld_shifted[15]}}, ld_shifted[15:0]};
        core_pkg::DRAM_RD_BU: ld_data = {{(XLEN-8){1'b0}}, ld_shifted[7:0]};
        core_pkg::DRAM_RD_HU: ld_data = {{(XLEN-16){1'b0}}, ld_shifted[15:0]};
        default:              ld_data = ld_shifted;
    endcase
end

always_comb begin
    case (rd_wr_sel_i)
        core_pkg::RD_WR_ALU:      direct_data = alu_data_i;
        core_pkg::RD_WR_PC_INC_4: direct_data = pc_inc_4;
        core_pkg::RD_WR_PC_INC_2: direct_data = pc_inc_2;
        default:                  direct_data = {XLEN{1'b0}};
    endcase
end

always_comb begin
    if (load_pending) begin
        reg_wr_en_o   = rd_wr_en_r_i;
        reg_wr_addr_o = rd_wr_addr_r_i;
        reg_wr_data_o = ld_data;
    end else begin
        reg_wr_en_o   = rd_wr_en_i && (rd_wr_sel_i != core_pkg::RD_WR_DRAM);
        reg_wr_addr_o = rd_wr_addr_i;
        reg_wr_data_o = direct_data;
    end
end

endmodule

// File: src/wb_ctrl.sv
`timescale 1ns/10ps

module wb_ctrl #(
    parameter XLEN = 32
) (
    input  logic                      clk_i,
    input  logic                      reset_i,

    input  logic                      op_valid_i,
    output logic                      op_ready_o,

    input  logic                      rd_wr_en_i,
    input  core_pkg::rd_wr_sel_e      rd_wr_sel_i,
    input  logic                [4:0] rd_addr_i,
    input  core_pkg::dram_rd_sel_e    dram_rd_sel_i,
    input  logic           [XLEN-1:0] alu_data_i,

    axil_rd_if.master                 axil,

    output logic                      rd_wr_en_o,
    output logic                      rd_wr_en_r_o,
    output core_pkg::rd_wr_sel_e      rd_wr_sel_r_o,
    output logic                [4:0] rd_wr_addr_r_o,
    output core_pkg::dram_rd_sel_e    dram_rd_sel_r_o,
    output logic           [XLEN-1:0] dram_rd_addr_r_o,

    output logic                      load_err_o
);

typedef enum logic [1:0] {IDLE, ADDR, RESP} state_e;

state_e state_q;
logic   ld_en_q;

wire is_load = (rd_wr_sel_i == core_pkg::RD_WR_DRAM);
wire accept  = op_valid_i && op_ready_o;
wire r_hs    = (state_q == RESP) && axil.rvalid;
wire resp_ok = (axil.rresp == core_pkg::AXI_RESP_OKAY);

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        state_q       <= IDLE;
        rd_wr_sel_r_o <= core_pkg::RD_WR_ALU;
        load_err_o    <= 1'b0;
    end else begin
        load_err_o <= r_hs && !resp_ok; // One cycle pulse after a failed read
        case (state_q)
            IDLE: begin
                if (accept && is_load) begin
                    state_q       <= ADDR;
                    rd_wr_sel_r_o <= core_pkg::RD_WR_DRAM;
                end
            end
            ADDR: begin
                if (axil.arready) state_q <= RESP;
            end
            RESP: begin
                if (axil.rvalid) begin
                    state_q       <= IDLE;
                    rd_wr_sel_r_o <= core_pkg::RD_WR_ALU;
                end
            end
            default: state_q <= IDLE;
        endcase
    end
end

always_ff @(posedge clk_i) begin
    if (accept && is_load) begin
        ld_en_q          <= rd_wr_en_i;
        rd_wr_addr_r_o   <= rd_addr_i;
        dram_rd_sel_r_o  <= dram_rd_sel_i;
        dram_rd_addr_r_o <= alu_data_i;
    end
end

assign op_ready_o   = (state_q == IDLE);
assign rd_wr_en_o   = rd_wr_en_i && accept && !is_load;
assign rd_wr_en_r_o = r_hs && resp_ok && ld_en_q; // Error responses never reach the register

assign axil.araddr  = dram_rd_addr_r_o;
assign axil.arvalid = (state_q == ADDR);
assign axil.rready  = (state_q == RESP);

endmodule

// File: src/wb_subsys.sv
`timescale 1ns/10ps

module wb_subsys #(
    parameter XLEN       = 32,
    parameter DRAM_WORDS = 16,
    parameter DRAM_LAT   = 2
) (
    input  logic            clk_i,
    input  logic            reset_i,

    input  logic            op_valid_i,
    output logic            op_ready_o,

    input  logic            rd_wr_en_i,
    input  logic      [1:0] rd_wr_sel_i,
    input  logic      [4:0] rd_addr_i,
    input  logic      [2:0] dram_rd_sel_i,
    input  logic [XLEN-1:0] pc_data_i,
    input  logic [XLEN-1:0] alu_data_i,

    input  logic      [4:0] rs_addr_i,
    output logic [XLEN-1:0] rs_data_o,

    output logic            load_err_o
);

core_pkg::rd_wr_sel_e   rd_wr_sel;
core_pkg::dram_rd_sel_e dram_rd_sel;

logic                   rd_wr_en_d;
logic                   rd_wr_en_r;
core_pkg::rd_wr_sel_e   rd_wr_sel_r;
logic             [4:0] rd_wr_addr_r;
core_pkg::dram_rd_sel_e dram_rd_sel_r;
logic        [XLEN-1:0] dram_rd_addr_r;

logic                   reg_wr_en;
logic             [4:0] reg_wr_addr;
logic        [XLEN-1:0] reg_wr_data;

assign rd_wr_sel   = core_pkg::rd_wr_sel_e'(rd_wr_sel_i);
assign dram_rd_sel = core_pkg::dram_rd_sel_e'(dram_rd_sel_i);

axil_rd_if #(.XLEN(XLEN)) axil_bus ();

wb_ctrl #(
    .XLEN(XLEN)
) wb_ctrl_inst (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .op_valid_i      (op_valid_i),
    .op_ready_o      (op_ready_o),
    .rd_wr_en_i      (rd_wr_en_i),
    .rd_wr_sel_i     (rd_wr_sel),
    .rd_addr_i       (rd_addr_i),
    .dram_rd_sel_i   (dram_rd_sel),
    .alu_data_i      (alu_data_i),
    .axil            (axil_bus.master),
    .rd_wr_en_o      (rd_wr_en_d),
    .rd_wr_en_r_o    (rd_wr_en_r),
    .rd_wr_sel_r_o   (rd_wr_sel_r),
    .rd_wr_addr_r_o  (rd_wr_addr_r),
    .dram_rd_sel_r_o (dram_rd_sel_r),
    .dram_rd_addr_r_o(dram_rd_addr_r),
    .load_err_o      (load_err_o)
);

dram_axil #(
    .XLEN      (XLEN),
    .DRAM_WORDS(DRAM_WORDS),
    .DRAM_LAT  (DRAM_LAT)
) dram_axil_inst (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .axil   (axil_bus.slave)
);

wb #(
    .XLEN(XLEN)
) wb_inst (
    .rd_wr_en_i     (rd_wr_en_d),
    .rd_wr_sel_i    (rd_wr_sel),
    .rd_wr_addr_i   (rd_addr_i),
    .rd_wr_en_r_i   (rd_wr_en_r),
    .rd_wr_sel_r_i  (rd_wr_sel_r),
    .rd_wr_addr_r_i (rd_wr_addr_r),
    .dram_rd_sel_r_i(dram_rd_sel_r),
    .pc_data_i      (pc_data_i),
    .alu_data_i     (alu_data_i),
    .dram_rd_addr_i (dram_rd_addr_r),
    .dram_rd_data_i (axil_bus.rdata), // Only meaningful on the R transfer edge
    .reg_wr_en_o    (reg_wr_en),
    .reg_wr_addr_o  (reg_wr_addr),
    .reg_wr_data_o  (reg_wr_data)
);

regfile #(
    .XLEN(XLEN)
) regfile_inst (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .wr_en_i  (reg_wr_en),
    .wr_addr_i(reg_wr_addr),
    .wr_data_i(reg_wr_data),
    .rs_addr_i(rs_addr_i),
    .rs_data_o(rs_data_o)
);

endmodule

// File: testbench/tb_wb_subsys.sv
`timescale 1ns/10ps

module tb_wb_subsys;

localparam int XLEN            = 32;
localparam int DRAM_WORDS      = 16;
localparam int DRAM_LAT        = 2;
localparam int N_RANDOM        = 200;
localparam int N_OPS           = N_RANDOM + 64 + 40;     // Random mix, read-backs, directed ops
localparam int WATCHDOG_CYCLES = N_OPS * (DRAM_LAT + 4) + 100;

logic            clk_i = 1'b0;
logic            reset_i = 1'b1;
logic            op_valid_i = 1'b0;
logic            rd_wr_en_i = 1'b0;
logic      [1:0] rd_wr_sel_i = 2'b00;
logic      [4:0] rd_addr_i = 5'd0;
logic      [2:0] dram_rd_sel_i = 3'b000;
logic [XLEN-1:0] pc_data_i = '0;
logic [XLEN-1:0] alu_data_i = '0;
logic      [4:0] rs_addr_i = 5'd0;
logic            op_ready_o;
logic [XLEN-1:0] rs_data_o;
logic            load_err_o;

logic [XLEN-1:0] dram_model [DRAM_WORDS];
logic [XLEN-1:0] shadow [32];
logic      [2:0] sizes [5];
int              seed = 72;
int              wr_cnt = 0;
int              exp_wr_cnt = 0;
int              ld_cnt = 0;
logic     [31:0] rnd;
logic     [31:0] rnd2;
logic     [31:0] addr;

wb_subsys #(
    .XLEN      (XLEN),
    .DRAM_WORDS(DRAM_WORDS),
    .DRAM_LAT  (DRAM_LAT)
) wb_subsys_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .op_valid_i   (op_valid_i),
    .op_ready_o   (op_ready_o),
    .rd_wr_en_i   (rd_wr_en_i),
    .rd_wr_sel_i  (rd_wr_sel_i),
    .rd_addr_i    (rd_addr_i),
    .dram_rd_sel_i(dram_rd_sel_i),
    .pc_data_i    (pc_data_i),
    .alu_data_i   (alu_data_i),
    .rs_addr_i    (rs_addr_i),
    .rs_data_o    (rs_data_o),
    .load_err_o   (load_err_o)
);

always #5 clk_i = ~clk_i;

task automatic report_fail(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("Regression failed");
    $fatal(1, "Stopped at the first error");
endtask

// Register write counter and load window tracker
always @(posedge clk_i) begin
    if (reset_i) begin
        ld_cnt <= 0;
    end else begin
        if (wb_subsys_inst.reg_wr_en && wb_subsys_inst.reg_wr_addr != 5'd0) begin
            wr_cnt <= wr_cnt + 1;
        end
        if (op_valid_i && op_ready_o && rd_wr_sel_i == core_pkg::RD_WR_DRAM) begin
            ld_cnt <= DRAM_LAT + 2;
        end else if (ld_cnt != 0) begin
            ld_cnt <= ld_cnt - 1;
        end
    end
end

ready_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (ld_cnt != 0) |-> !op_ready_o)
    else report_fail("op_ready_o rose while a load was outstanding");

ready_back: assert property (@(posedge clk_i) disable iff (reset_i)
    (ld_cnt == 1) |=> op_ready_o)
    else report_fail("op_ready_o did not return after DRAM_LAT+2 edges");

direct_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    (op_valid_i && op_ready_o && rd_wr_sel_i != core_pkg::RD_WR_DRAM) |=> op_ready_o)
    else report_fail("op_ready_o dropped after an ALU or link op");

err_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    load_err_o |=> !load_err_o)
    else report_fail("load_err_o held high for more than one cycle");

// Byte and halfword lanes picked by address, then extended by size
function automatic logic [31:0] load_value(input logic [31:0] word, input logic [2:0] size,
                                           input logic [31:0] a);
    logic  [7:0] b;
    logic [15:0] h;
    b = word[8*a[1:0] +: 8];
    h = word[16*a[1] +: 16];
    case (size)
        core_pkg::DRAM_RD_B:  return {{24{b[7]}}, b};
        core_pkg::DRAM_RD_BU: return {24'h0, b};
        core_pkg::DRAM_RD_H:  return {{16{h[15]}}, h};
        core_pkg::DRAM_RD_HU: return {16'h0, h};
        default:              return word;
    endcase
endfunction

task automatic issue(input logic en, input logic [1:0] sel, input logic [4:0] rd,
                     input logic [2:0] size, input logic [31:0] pc, input logic [31:0] alu);
    @(negedge clk_i);
    rd_wr_en_i    = en;
    rd_wr_sel_i   = sel;
    rd_addr_i     = rd;
    dram_rd_sel_i = size;
    pc_data_i     = pc;
    alu_data_i    = alu;
    op_valid_i    = 1'b1;
    while (!op_ready_o) @(negedge clk_i); // Payload holds under back-pressure
    @(posedge clk_i);
    @(negedge clk_i);
    op_valid_i = 1'b0;
endtask

task automatic check_reg(input logic [4:0] a, input logic [31:0] exp);
    rs_addr_i = a;
    #1;
    assert (rs_data_o == exp)
        else report_fail($sformatf("x%0d reads %h, expected %h", a, rs_data_o, exp));
endtask

task automatic alu_op(input logic en, input logic [1:0] sel, input logic [4:0] rd,
                      input logic [31:0] pc, input logic [31:0] alu);
    issue(en, sel, rd, core_pkg::DRAM_RD_W, pc, alu);
    if (en && rd != 5'd0) begin
        exp_wr_cnt++;
        case (sel)
            core_pkg::RD_WR_PC_INC_4: shadow[rd] = pc + 32'd4;
            core_pkg::RD_WR_PC_INC_2: shadow[rd] = pc + 32'd2;
            default:                  shadow[rd] = alu;
        endcase
    end
endtask

function automatic void load_shadow(input logic en, input logic [4:0] rd,
                                    input logic [2:0] size, input logic [31:0] a);
    if (en && rd != 5'd0 && a[31:2] < DRAM_WORDS) begin
        exp_wr_cnt++;
        shadow[rd] = load_value(dram_model[a[5:2]], size, a);
    end
endfunction

task automatic load_op(input logic en, input logic [4:0] rd, input logic [2:0] size,
                       input logic [31:0] a);
    int lat;
    lat = 0;
    issue(en, core_pkg::RD_WR_DRAM, rd, size, 32'h0, a);
    while (!op_ready_o) begin
        @(negedge clk_i);
        lat++;
    end
    assert (lat == DRAM_LAT + 2)
        else report_fail($sformatf("load latency %0d, expected %0d", lat, DRAM_LAT + 2));
    assert (load_err_o == (a[31:2] >= DRAM_WORDS))
        else report_fail($sformatf("load_err_o is %b for address %h", load_err_o, a));
    load_shadow(en, rd, size, a);
endtask

initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("Watchdog expired before the tests finished");
    $display("Regression failed");
    $fatal(1, "Run did not complete");
end

initial begin
    $readmemh("dram_init.hex", dram_model);
    sizes = '{core_pkg::DRAM_RD_B, core_pkg::DRAM_RD_H, core_pkg::DRAM_RD_W,
              core_pkg::DRAM_RD_BU, core_pkg::DRAM_RD_HU};
    for (int i = 0; i < 32; i++) shadow[i] = '0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    assert (op_ready_o && !load_err_o) else report_fail("bad handshake state after reset");
    for (int i = 0; i < 32; i++) begin
        @(negedge clk_i);
        check_reg(i[4:0], 32'h0);
    end

    alu_op(1'b1, core_pkg::RD_WR_ALU, 5'd1, 32'h0, 32'hdeadbeef);
    check_reg(5'd1, 32'hdeadbeef);
    alu_op(1'b1, core_pkg::RD_WR_PC_INC_4, 5'd2, 32'h0000_1000, 32'h5555_5555);
    check_reg(5'd2, 32'h0000_1004);
    alu_op(1'b1, core_pkg::RD_WR_PC_INC_2, 5'd3, 32'h0000_1000, 32'h5555_5555);
    check_reg(5'd3, 32'h0000_1002);
    alu_op(1'b1, core_pkg::RD_WR_ALU, 5'd0, 32'h0, 32'hffff_ffff);
    check_reg(5'd0, 32'h0);
    alu_op(1'b0, core_pkg::RD_WR_ALU, 5'd1, 32'h0, 32'h0000_1234); // Disabled write
    check_reg(5'd1, 32'hdeadbeef);

    for (int s = 0; s < 5; s++) begin
        for (int off = 0; off < 4; off++) begin
            addr = {26'h0, 4'((s * 3 + off) % DRAM_WORDS), 2'(off)};
            load_op(1'b1, 5'(8 + off), sizes[s], addr);
            check_reg(5'(8 + off), shadow[8 + off]);
        end
    end

    issue(1'b1, core_pkg::RD_WR_DRAM, 5'd14, core_pkg::DRAM_RD_W, 32'h0, 32'h0000_0014);
    load_shadow(1'b1, 5'd14, core_pkg::DRAM_RD_W, 32'h0000_0014);
    alu_op(1'b1, core_pkg::RD_WR_ALU, 5'd15, 32'h0, 32'h0bad_cafe); // Held behind the load
    check_reg(5'd14, shadow[14]);
    check_reg(5'd15, 32'h0bad_cafe);
    assert (wr_cnt == exp_wr_cnt) else report_fail("held op was not written exactly once");

    alu_op(1'b1, core_pkg::RD_WR_ALU, 5'd16, 32'h0, 32'h1357_2468);
    load_op(1'b1, 5'd16, core_pkg::DRAM_RD_W, 32'h0000_0100);
    check_reg(5'd16, 32'h1357_2468);

    for (int n = 0; n < N_RANDOM; n++) begin
        rnd  = $random(seed);
        rnd2 = $random(seed);
        if (rnd[1:0] == core_pkg::RD_WR_DRAM) begin
            addr = (rnd2[15:13] == 3'b000) ? {24'h0, 2'b01, rnd2[8:3]} : {26'h0, rnd2[8:3]};
            load_op(rnd[9:7] != 3'b000, rnd[6:2], sizes[rnd2[2:0] % 5], addr);
        end else begin
            alu_op(rnd[9:7] != 3'b000, rnd[1:0], rnd[6:2], rnd2, $random(seed));
        end
    end

    for (int i = 0; i < 32; i++) begin
        @(negedge clk_i);
        check_reg(i[4:0], shadow[i]);
    end
    assert (wr_cnt == exp_wr_cnt) else report_fail("register write count does not match ops");

    $display("Regression passed");
    $finish;
end

endmodule
